/* project.f */
+incdir+tb
verilog/bp_pkg.sv
verilog/branch_target_buffer.sv
verilog/branch_history_table.sv
verilog/prediction_resolver.sv
verilog/perf_counters.sv
verilog/branch_predictor.sv
tb/tb_branch_predictor.sv

/* tb/bp_ref_model.svh */
`ifndef BP_REF_MODEL_SVH
`define BP_REF_MODEL_SVH

    // ------------------------------------------------------------------
    // Mirrored tables and statistics
    // ------------------------------------------------------------------

    typedef struct packed {
        addr_t   predict_pc;
        logic    redirect_valid;
        addr_t   redirect_pc;
        btb_op_e op;
    } expect_t;

    localparam int REF_BTB_SIZE = 1 << BTB_BITS;
    localparam int REF_BHT_SIZE = 1 << BHT_BITS;

    logic        ref_valid  [REF_BTB_SIZE];
    addr_t       ref_tag    [REF_BTB_SIZE];
    addr_t       ref_target [REF_BTB_SIZE];
    // 0 strongly not taken up to 3 strongly taken
    int          ref_count  [REF_BHT_SIZE];
    logic [31:0] ref_branches;
    logic [31:0] ref_mispredicts;
    logic [31:0] lcg_state;

    function automatic int btb_slot(input addr_t pc);
        return (pc >> 2) % REF_BTB_SIZE;
    endfunction

    function automatic int bht_slot(input addr_t pc);
        return (pc >> 2) % REF_BHT_SIZE;
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    task automatic clear_tables();
        for (int i = 0; i < REF_BTB_SIZE; i++)
        begin
            ref_valid[i]  = 1'b0;
            ref_tag[i]    = '0;
            ref_target[i] = '0;
        end
        for (int i = 0; i < REF_BHT_SIZE; i++)
            ref_count[i] = 1;
        ref_branches    = '0;
        ref_mispredicts = '0;
    endtask

    // Expected outputs for a fetch PC and a resolve report
    function automatic expect_t expected_outputs(input addr_t fpc, input resolve_t r);
        expect_t e;
        int      fs;
        int      rs;
        logic    fhit;
        logic    rhit;
        addr_t   next_pc;
        fs   = btb_slot(fpc);
        rs   = btb_slot(r.pc);
        fhit = ref_valid[fs] && (ref_tag[fs] == (fpc >> (2 + BTB_BITS)));
        rhit = ref_valid[rs] && (ref_tag[rs] == (r.pc >> (2 + BTB_BITS)));
        e.predict_pc = (fhit && ref_count[bht_slot(fpc)] >= 2) ? ref_target[fs] : fpc + 4;
        next_pc = r.taken ? r.target : r.pc + 4;
        e.redirect_valid = r.valid && (next_pc != r.predicted);
        e.redirect_pc    = next_pc;
        e.op = BTB_NONE;
        if (r.valid && r.taken && !rhit)
            e.op = BTB_ADD;
        else if (r.valid && r.taken && ref_target[rs] != r.target)
            e.op = BTB_UPDATE;
        else if (r.valid && !r.taken && rhit && ref_count[bht_slot(r.pc)] < 2)
            e.op = BTB_REMOVE;
        return e;
    endfunction

    // Applies one report to the mirrored state, as the clock edge does
    task automatic learn_report(input resolve_t r);
        expect_t e;
        int      rs;
        int      hs;
        e  = expected_outputs(r.pc, r);
        rs = btb_slot(r.pc);
        hs = bht_slot(r.pc);
        if (r.valid)
        begin
            if (e.op == BTB_ADD || e.op == BTB_UPDATE)
            begin
                ref_valid[rs]  = 1'b1;
                ref_tag[rs]    = r.pc >> (2 + BTB_BITS);
                ref_target[rs] = r.target;
            end
            else if (e.op == BTB_REMOVE)
                ref_valid[rs] = 1'b0;
            if (r.taken && ref_count[hs] < 3)
                ref_count[hs]++;
            else if (!r.taken && ref_count[hs] > 0)
                ref_count[hs]--;
            ref_branches++;
            if (e.redirect_valid)
                ref_mispredicts++;
        end
    endtask

`endif

/* tb/tb_branch_predictor.sv */
module tb_branch_predictor;
    timeunit 1ns;
    timeprecision 100ps;
    import bp_pkg::*;

    localparam int BTB_BITS        = 7;
    localparam int BHT_BITS        = 7;
    localparam int RESET_CYCLES    = 16;
    localparam int DIRECTED_CYCLES = 16;
    localparam int RANDOM_REPORTS  = 400;
    localparam int TOTAL_CYCLES    = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_REPORTS;

    localparam addr_t PC_A     = 32'h0000_1000;
    localparam addr_t TARGET_1 = 32'h0000_2000;
    localparam addr_t TARGET_2 = 32'h0000_3000;
    localparam addr_t PC_B     = 32'h0000_5010;
    // Same BTB index as PC_B but a different tag
    localparam addr_t PC_ALIAS = PC_B + (32'd1 << (2 + BTB_BITS));
    localparam addr_t TARGET_B = 32'h0000_6000;

    logic        CPU_CLK;
    logic        CPU_RST;
    addr_t       fetch_pc;
    addr_t       predict_pc;
    resolve_t    resolve;
    logic        redirect_valid;
    addr_t       redirect_pc;
    logic [31:0] branch_count;
    logic [31:0] mispredict_count;
    string       test_name;

    `include "bp_ref_model.svh"

    expect_t     now_exp;

    branch_predictor #(
        .BTB_INDEX_BITS(BTB_BITS),
        .BHT_INDEX_BITS(BHT_BITS)
    ) uut (
        .CPU_CLK         (CPU_CLK),
        .CPU_RST         (CPU_RST),
        .fetch_pc        (fetch_pc),
        .predict_pc      (predict_pc),
        .resolve         (resolve),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .branch_count    (branch_count),
        .mispredict_count(mispredict_count)
    );

    initial
    begin
        CPU_CLK = 1'b0;
        forever #4 CPU_CLK = ~CPU_CLK;
    end

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("Fail %s: %s expected %h actual %h", test_name, what, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Output mismatch");
        end
    endtask

    // Drives one cycle of stimulus and returns just after the falling edge
    task automatic drive_cycle(input addr_t fpc, input logic valid, input addr_t bpc,
                               input logic taken, input addr_t target);
        resolve_t r;
        expect_t  fetched;
        @(posedge CPU_CLK);
        #1;
        fetched     = expected_outputs(bpc, '0);
        r.valid     = valid;
        r.pc        = bpc;
        r.taken     = taken;
        r.target    = target;
        r.predicted = fetched.predict_pc;
        fetch_pc    = fpc;
        resolve     = r;
        @(negedge CPU_CLK);
        #1;
    endtask

    function automatic addr_t pool_pc();
        return 32'h0000_8000 + ((lcg_next() % 6) << 2) + ((lcg_next() % 2) << (2 + BTB_BITS));
    endfunction

    // ------------------------------------------------------------------
    // Reference tracking and comparison
    // ------------------------------------------------------------------

    always @(posedge CPU_CLK)
    begin
        if (!CPU_RST)
            learn_report(resolve);
    end

    always @(negedge CPU_CLK)
    begin
        if (!CPU_RST)
        begin
            now_exp = expected_outputs(fetch_pc, resolve);
            check_value("predict_pc", now_exp.predict_pc, predict_pc);
            check_value("redirect_valid", now_exp.redirect_valid, redirect_valid);
            check_value("redirect_pc", now_exp.redirect_pc, redirect_pc);
            check_value("btb_op", now_exp.op, uut.btb_op);
            check_value("branch_count", ref_branches, branch_count);
            check_value("mispredict_count", ref_mispredicts, mispredict_count);
        end
    end

    initial
    begin
        #(2 * TOTAL_CYCLES * 8);
        $display("Timeout: tests did not finish within %0d clock cycles", 2 * TOTAL_CYCLES);
        $display("Simulation failed");
        $fatal(1, "Watchdog expired");
    end

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------

    initial
    begin
        CPU_RST   = 1'b1;
        fetch_pc  = '0;
        resolve   = '0;
        lcg_state = 32'd99;
        test_name = "reset";
        clear_tables();
        repeat (RESET_CYCLES) @(posedge CPU_CLK);
        #1;
        CPU_RST = 1'b0;

        drive_cycle(32'h0000_0100, 1'b0, 32'h0, 1'b0, 32'h0);
        check_value("predict_pc", 32'h0000_0104, predict_pc);
        check_value("branch_count", 32'd0, branch_count);
        check_value("mispredict_count", 32'd0, mispredict_count);

        test_name = "add";
        drive_cycle(PC_A, 1'b1, PC_A, 1'b1, TARGET_1);
        check_value("redirect_valid", 32'd1, redirect_valid);
        check_value("redirect_pc", TARGET_1, redirect_pc);
        check_value("btb_op", BTB_ADD, uut.btb_op);
        drive_cycle(PC_A, 1'b0, PC_A, 1'b0, 32'h0);
        check_value("predict_pc", TARGET_1, predict_pc);

        test_name = "update";
        drive_cycle(PC_A, 1'b1, PC_A, 1'b1, TARGET_2);
        check_value("redirect_valid", 32'd1, redirect_valid);
        check_value("redirect_pc", TARGET_2, redirect_pc);
        check_value("btb_op", BTB_UPDATE, uut.btb_op);
        drive_cycle(PC_A, 1'b0, PC_A, 1'b0, 32'h0);
        check_value("mispredict_count", 32'd2, mispredict_count);
        check_value("predict_pc", TARGET_2, predict_pc);

        // Counter starts at strong taken so the third report removes the entry
        test_name = "remove";
        for (int i = 0; i < 3; i++)
        begin
            drive_cycle(PC_A, 1'b1, PC_A, 1'b0, 32'h0);
            check_value("btb_op", (i == 2) ? BTB_REMOVE : BTB_NONE, uut.btb_op);
        end
        drive_cycle(PC_A, 1'b0, PC_A, 1'b0, 32'h0);
        check_value("predict_pc", PC_A + 32'd4, predict_pc);

        test_name = "alias";
        drive_cycle(PC_B, 1'b1, PC_B, 1'b1, TARGET_B);
        drive_cycle(PC_ALIAS, 1'b0, PC_B, 1'b0, 32'h0);
        check_value("predict_pc", PC_ALIAS + 32'd4, predict_pc);
        drive_cycle(PC_B, 1'b0, PC_B, 1'b0, 32'h0);
        check_value("predict_pc", TARGET_B, predict_pc);

        test_name = "random";
        for (int i = 0; i < RANDOM_REPORTS; i++)
            drive_cycle(pool_pc(), 1'b1, pool_pc(), (lcg_next() % 3) != 0,
                        32'h0000_A000 + ((lcg_next() % 3) << 4));
        drive_cycle(PC_A, 1'b0, PC_A, 1'b0, 32'h0);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* verilog/bp_pkg.sv */
package bp_pkg;

    // ------------------------------------------------------------------
    // Addresses
    // ------------------------------------------------------------------

    typedef logic [31:0] addr_t;

    // Step from one instruction to the next
    localparam addr_t INST_BYTES = 32'd4;

    // Low PC bits below the table index, always zero for aligned code
    localparam int PC_OFFSET = $clog2(INST_BYTES);

    // ------------------------------------------------------------------
    // Resolve report from execute
    // ------------------------------------------------------------------

    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  taken;
        addr_t target;
        // Next PC that was predicted at fetch time
        addr_t predicted;
    } resolve_t;

    // ------------------------------------------------------------------
    // Table encodings
    // ------------------------------------------------------------------

    typedef enum logic [1:0] {
        BTB_NONE   = 2'd0,
        BTB_ADD    = 2'd1,
        BTB_UPDATE = 2'd2,
        BTB_REMOVE = 2'd3
    } btb_op_e;

    // High bit set means predict taken
    typedef enum logic [1:0] {
        STRONG_NOT   = 2'b00,
        WEAK_NOT     = 2'b01,
        WEAK_TAKEN   = 2'b10,
        STRONG_TAKEN = 2'b11
    } bht_state_e;

endpackage

/* verilog/branch_history_table.sv */
module branch_history_table #(
    parameter int BHT_INDEX_BITS = 7
) (
    input  logic             CPU_CLK,
    input  logic             CPU_RST,
    input  bp_pkg::addr_t    lookup_pc,
    output logic             lookup_taken,
    input  bp_pkg::resolve_t resolve,
    output logic             resolve_taken
);
    import bp_pkg::*;

    localparam int ENTRIES = 1 << BHT_INDEX_BITS;

    bht_state_e                counter [ENTRIES];
    logic [BHT_INDEX_BITS-1:0] lookup_idx;
    logic [BHT_INDEX_BITS-1:0] resolve_idx;

    // Saturating step, up on taken and down on not taken
    function automatic bht_state_e next_state(input bht_state_e cur, input logic taken);
        bht_state_e nxt;
        case (cur)
            STRONG_NOT:   nxt = taken ? WEAK_NOT     : STRONG_NOT;
            WEAK_NOT:     nxt = taken ? WEAK_TAKEN   : STRONG_NOT;
            WEAK_TAKEN:   nxt = taken ? STRONG_TAKEN : WEAK_NOT;
            STRONG_TAKEN: nxt = taken ? STRONG_TAKEN : WEAK_TAKEN;
            default:      nxt = WEAK_NOT;
        endcase
        return nxt;
    endfunction

    assign lookup_idx  = lookup_pc[PC_OFFSET+BHT_INDEX_BITS-1:PC_OFFSET];
    assign resolve_idx = resolve.pc[PC_OFFSET+BHT_INDEX_BITS-1:PC_OFFSET];

    // Counter state before this report's update
    assign lookup_taken  = counter[lookup_idx][1];
    assign resolve_taken = counter[resolve_idx][1];

    // ------------------------------------------------------------------
    // Counter update
    // ------------------------------------------------------------------

    always_ff @(posedge CPU_CLK or posedge CPU_RST)
    begin
        if (CPU_RST)
        begin
            for (int i = 0; i < ENTRIES; i++)
                counter[i] <= WEAK_NOT;
        end
        else if (resolve.valid)
        begin
            counter[resolve_idx] <= next_state(counter[resolve_idx], resolve.taken);
        end
    end

endmodule

/* verilog/branch_predictor.sv */
module branch_predictor #(
    parameter int BTB_INDEX_BITS = 7,
    parameter int BHT_INDEX_BITS = 7
) (
    input  logic             CPU_CLK,
    input  logic             CPU_RST,
    input  bp_pkg::addr_t    fetch_pc,
    output bp_pkg::addr_t    predict_pc,
    input  bp_pkg::resolve_t resolve,
    output logic             redirect_valid,
    output bp_pkg::addr_t    redirect_pc,
    output logic [31:0]      branch_count,
    output logic [31:0]      mispredict_count
);
    import bp_pkg::*;

    logic     btb_fetch_hit;
    addr_t    btb_fetch_target;
    logic     btb_resolve_hit;
    addr_t    btb_resolve_target;
    logic     bht_fetch_taken;
    logic     bht_resolve_taken;
    btb_op_e  btb_op;
    logic     mispredict;

    // Jump only when both tables agree
    assign predict_pc = (btb_fetch_hit && bht_fetch_taken) ? btb_fetch_target
                                                           : fetch_pc + INST_BYTES;

    // ------------------------------------------------------------------
    // Tables
    // ------------------------------------------------------------------

    branch_target_buffer #(
        .BTB_INDEX_BITS(BTB_INDEX_BITS)
    ) u_btb (
        .CPU_CLK       (CPU_CLK),
        .CPU_RST       (CPU_RST),
        .lookup_pc     (fetch_pc),
        .lookup_hit    (btb_fetch_hit),
        .lookup_target (btb_fetch_target),
        .resolve_pc    (resolve.pc),
        .resolve_hit   (btb_resolve_hit),
        .resolve_target(btb_resolve_target),
        .op            (btb_op),
        .new_target    (resolve.target)
    );

    branch_history_table #(
        .BHT_INDEX_BITS(BHT_INDEX_BITS)
    ) u_bht (
        .CPU_CLK      (CPU_CLK),
        .CPU_RST      (CPU_RST),
        .lookup_pc    (fetch_pc),
        .lookup_taken (bht_fetch_taken),
        .resolve      (resolve),
        .resolve_taken(bht_resolve_taken)
    );

    // ------------------------------------------------------------------
    // Resolve path and statistics
    // ------------------------------------------------------------------

    prediction_resolver u_resolver (
        .resolve       (resolve),
        .btb_hit       (btb_resolve_hit),
        .btb_target    (btb_resolve_target),
        .bht_taken     (bht_resolve_taken),
        .op            (btb_op),
        .redirect_valid(redirect_valid),
        .redirect_pc   (redirect_pc),
        .mispredict    (mispredict)
    );

    perf_counters u_counters (
        .CPU_CLK         (CPU_CLK),
        .CPU_RST         (CPU_RST),
        .branch_valid    (resolve.valid),
        .mispredict      (mispredict),
        .branch_count    (branch_count),
        .mispredict_count(mispredict_count)
    );

endmodule

/* verilog/branch_target_buffer.sv */
module branch_target_buffer #(
    parameter int BTB_INDEX_BITS = 7
) (
    input  logic            CPU_CLK,
    input  logic            CPU_RST,
    input  bp_pkg::addr_t   lookup_pc,
    output logic            lookup_hit,
    output bp_pkg::addr_t   lookup_target,
    input  bp_pkg::addr_t   resolve_pc,
    output logic            resolve_hit,
    output bp_pkg::addr_t   resolve_target,
    input  bp_pkg::btb_op_e op,
    input  bp_pkg::addr_t   new_target
);
    import bp_pkg::*;

    localparam int ENTRIES  = 1 << BTB_INDEX_BITS;
    localparam int TAG_LSB  = PC_OFFSET + BTB_INDEX_BITS;
    localparam int TAG_BITS = 32 - TAG_LSB;

    logic                      entry_valid  [ENTRIES];
    logic [TAG_BITS-1:0]       entry_tag    [ENTRIES];
    addr_t                     entry_target [ENTRIES];

    logic [BTB_INDEX_BITS-1:0] lookup_idx;
    logic [TAG_BITS-1:0]       lookup_tag;
    logic [BTB_INDEX_BITS-1:0] resolve_idx;
    logic [TAG_BITS-1:0]       resolve_tag;
    logic                      write_entry;

    // ------------------------------------------------------------------
    // Address split
    // ------------------------------------------------------------------

    assign lookup_idx  = lookup_pc[TAG_LSB-1:PC_OFFSET];
    assign lookup_tag  = lookup_pc[31:TAG_LSB];
    assign resolve_idx = resolve_pc[TAG_LSB-1:PC_OFFSET];
    assign resolve_tag = resolve_pc[31:TAG_LSB];

    // Fetch port
    assign lookup_hit    = entry_valid[lookup_idx] && (entry_tag[lookup_idx] == lookup_tag);
    assign lookup_target = entry_target[lookup_idx];

    // Resolve port reads the entry that the write below touches
    assign resolve_hit    = entry_valid[resolve_idx] && (entry_tag[resolve_idx] == resolve_tag);
    assign resolve_target = entry_target[resolve_idx];

    assign write_entry = (op == BTB_ADD) || (op == BTB_UPDATE);

    // ------------------------------------------------------------------
    // Entry writes
    // ------------------------------------------------------------------

    always_ff @(posedge CPU_CLK or posedge CPU_RST)
    begin
        if (CPU_RST)
        begin
            for (int i = 0; i < ENTRIES; i++)
                entry_valid[i] <= 1'b0;
        end
        else
        begin
            if (write_entry)
                entry_valid[resolve_idx] <= 1'b1;
            else if (op == BTB_REMOVE)
                entry_valid[resolve_idx] <= 1'b0;
        end
    end

    // Tag and target of each entry
    always_ff @(posedge CPU_CLK)
    begin
        if (write_entry)
        begin
            entry_tag[resolve_idx]    <= resolve_tag;
            entry_target[resolve_idx] <= new_target;
        end
    end

endmodule

/* verilog/perf_counters.sv */
module perf_counters (
    input  logic        CPU_CLK,
    input  logic        CPU_RST,
    input  logic        branch_valid,
    input  logic        mispredict,
    output logic [31:0] branch_count,
    output logic [31:0] mispredict_count
);

    // Resolved branches
    always_ff @(posedge CPU_CLK or posedge CPU_RST)
    begin
        if (CPU_RST)
            branch_count <= 32'd0;
        else if (branch_valid)
            branch_count <= branch_count + 32'd1;
    end

    // Reports that needed a redirect
    always_ff @(posedge CPU_CLK or posedge CPU_RST)
    begin
        if (CPU_RST)
            mispredict_count <= 32'd0;
        else if (mispredict)
            mispredict_count <= mispredict_count + 32'd1;
    end

endmodule

/* verilog/prediction_resolver.sv */
module prediction_resolver (
    input  bp_pkg::resolve_t resolve,
    input  logic             btb_hit,
    input  bp_pkg::addr_t    btb_target,
    input  logic             bht_taken,
    output bp_pkg::btb_op_e  op,
    output logic             redirect_valid,
    output bp_pkg::addr_t    redirect_pc,
    output logic             mispredict
);
    import bp_pkg::*;

    addr_t correct_pc;
    logic  wrong_path;

    // ------------------------------------------------------------------
    // Misprediction check
    // ------------------------------------------------------------------

    // Where fetch should have gone after this branch
    assign correct_pc = resolve.taken ? resolve.target : resolve.pc + INST_BYTES;
    assign wrong_path = resolve.valid && (correct_pc != resolve.predicted);

    assign redirect_valid = wrong_path;
    assign redirect_pc    = correct_pc;
    assign mispredict     = wrong_path;

    // ------------------------------------------------------------------
    // BTB maintenance
    // ------------------------------------------------------------------

    always_comb
    begin
        op = BTB_NONE;
        if (resolve.valid)
        begin
            if (resolve.taken)
            begin
                if (!btb_hit)
                    op = BTB_ADD;
                else if (btb_target != resolve.target)
                    op = BTB_UPDATE;
            end
            else if (btb_hit && !bht_taken)
            begin
                // Entry already predicts fall-through, drop it
                op = BTB_REMOVE;
            end
        end
    end

endmodule
